// File: build.f
fmaPkg.sv
fmaDelayLine.sv
fmaDecode.sv
fmaMultiplier.sv
fmaAligner.sv
fmaAdder.sv
fmaTop.sv
fma_assertions.sv
fmaTb.sv

// File: fmaTb.sv
`timescale 1ns/1ps

module fmaTb import fmaPkg::*; ();

	// expected result and flags of one operation
	typedef struct packed {
		fmaResult_t res;
		fmaFlags_t flg;
	} expEntry_t;

	logic clk = 1'b0;
	logic reset;
	logic ce;
	logic inValid;
	logic [FP_WID-1:0] a;
	logic [FP_WID-1:0] b;
	logic [FP_WID-1:0] c;
	fmaCmd_t cmd;
	fmaResult_t result;
	fmaFlags_t flags;
	logic outValid;

	// scoreboard, one entry per accepted operation
	expEntry_t expQ[$];
	string nameQ[$];
	int issueQ[$];
	string curName;
	bit randomCe;
	// enabled clock edges since reset
	int enCount = 0;

	fmaTop i_dut (
		.clk(clk), .reset(reset), .ce(ce), .inValid(inValid), .a(a), .b(b), .c(c),
		.cmd(cmd), .result(result), .flags(flags), .outValid(outValid)
	);

	always #5 clk = ~clk;

	// ------------------------------------------------------------------------
	// reporting
	// ------------------------------------------------------------------------
	task automatic stopWithFailure();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %0h actual %0h", name, expected, actual);
			stopWithFailure();
		end
	endtask

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	function automatic fpOperand_t decodeRef(input logic [FP_WID-1:0] w);
		fpOperand_t d;
		d.sign = w[31];
		// denormal acts as exponent 1 without hidden bit
		d.exp = (w[30:23] == 8'd0) ? 8'd1 : w[30:23];
		d.mant = {w[30:23] != 8'd0, w[22:0]};
		d.cls.zero = (w[30:0] == 31'd0);
		d.cls.denorm = (w[30:23] == 8'd0) && (w[22:0] != 23'd0);
		d.cls.inf = (w[30:23] == 8'hff) && (w[22:0] == 23'd0);
		d.cls.nan = (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
		return d;
	endfunction

	function automatic expEntry_t fmaRef(input logic [FP_WID-1:0] ra,
			input logic [FP_WID-1:0] rb, input logic [FP_WID-1:0] rc, input fmaCmd_t rcmd);
		fpOperand_t da;
		fpOperand_t db;
		fpOperand_t dc;
		expEntry_t r;
		logic [PROD_W-1:0] pm;
		logic [ALIGN_W-1:0] pAl;
		logic [ALIGN_W-1:0] cAl;
		logic [ALIGN_W-1:0] big;
		logic [ALIGN_W-1:0] smaller;
		logic [SUM_W-1:0] sum;
		int pe;
		int ec;
		int re;
		int diff;
		logic ps;
		logic cs;
		logic effSub;
		logic prodLarger;
		logic magEq;
		logic sticky;
		logic pNan;
		logic pInf;
		da = decodeRef(ra);
		db = decodeRef(rb);
		dc = decodeRef(rc);
		r = '0;
		// product, point after bit 46, exponent 0 for a zero product
		pm = PROD_W'(da.mant) * PROD_W'(db.mant);
		ps = da.sign ^ db.sign;
		pe = (da.cls.zero || db.cls.zero) ? 0 : int'(da.exp) + int'(db.exp) - EXP_BIAS;
		pNan = da.cls.nan | db.cls.nan | (da.cls.inf & db.cls.zero) | (db.cls.inf & da.cls.zero);
		pInf = da.cls.inf | db.cls.inf;
		cs = dc.sign ^ rcmd.op;
		effSub = ps ^ cs;
		ec = int'(dc.exp);
		pAl = {pm, 2'b00};
		// addend hidden bit lines up with the product point
		cAl = {1'b0, dc.mant, 25'd0};
		if (pNan || dc.cls.nan || (pInf && dc.cls.inf && effSub)) begin
			r.flg.nan = 1'b1;
		end else if (pInf || dc.cls.inf) begin
			r.flg.inf = 1'b1;
			r.res.sign = pInf ? ps : cs;
		end else begin
			// zero addend never wins, otherwise exponent then mantissa
			prodLarger = dc.cls.zero || (pm != 0 && ((pe > ec) || (pe == ec && pAl >= cAl)));
			big = prodLarger ? pAl : cAl;
			smaller = prodLarger ? cAl : pAl;
			re = prodLarger ? pe : ec;
			diff = prodLarger ? pe - ec : ec - pe;
			diff = (diff < 0) ? 0 : (diff > ALIGN_W) ? ALIGN_W : diff;
			// bits that fall off the bottom collapse into bit 0
			sticky = ((smaller >> diff) << diff) != smaller;
			smaller = (smaller >> diff) | ALIGN_W'(sticky);
			sum = effSub ? SUM_W'(big) - SUM_W'(smaller) :
				SUM_W'(big) + SUM_W'(smaller);
			magEq = (pe == ec && pAl == cAl) || (pm == 0 && cAl == 0);
			r.res.sign = (effSub && magEq) ? (rcmd.rm == RM_DOWN) : (prodLarger ? ps : cs);
			r.res.exp = WEXP_W'(re);
			r.res.mant = sum;
			r.flg.zero = (sum == 0);
			r.flg.over = (re >= EXP_MAX);
			r.flg.under = (sum != 0) && (re <= 0);
		end
		return r;
	endfunction

	// ------------------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------------------
	// ce low about one cycle in five in the random phase
	function automatic logic nextCe();
		return randomCe ? ($urandom_range(99) >= 20) : 1'b1;
	endfunction

	function automatic logic [FP_WID-1:0] randOperand();
		int kind;
		logic sign;
		logic [7:0] e;
		logic [22:0] f;
		kind = $urandom_range(99);
		sign = 1'($urandom_range(1));
		f = 23'($urandom);
		if (kind < 45) begin
			e = 8'($urandom_range(114, 140));
		end else if (kind < 60) begin
			e = 8'($urandom_range(1, 254));
		end else if (kind < 70) begin
			// denormal, fraction must stay nonzero
			e = 8'd0;
			f = (f == 23'd0) ? 23'd1 : f;
		end else if (kind < 80) begin
			e = (kind < 75) ? 8'd1 : 8'd254;
		end else if (kind < 86) begin
			e = 8'd0;
			f = 23'd0;
		end else if (kind < 89) begin
			e = 8'hff;
			f = 23'd0;
		end else if (kind < 91) begin
			e = 8'hff;
			f = f | 23'h400000;
		end else begin
			e = 8'($urandom_range(100, 154));
		end
		return {sign, e, f};
	endfunction

	// present one operation and hold it until an enabled edge takes it
	task automatic issueOp(input string name, input logic [FP_WID-1:0] opA,
			input logic [FP_WID-1:0] opB, input logic [FP_WID-1:0] opC,
			input logic op, input logic [2:0] rm);
		int tries;
		@(negedge clk);
		a = opA;
		b = opB;
		c = opC;
		cmd.op = op;
		cmd.rm = rm;
		inValid = 1'b1;
		curName = name;
		ce = nextCe();
		tries = 0;
		while (!ce) begin
			tries++;
			if (tries > 50) begin
				$display("operation %s was never accepted", name);
				stopWithFailure();
			end
			@(negedge clk);
			ce = nextCe();
		end
	endtask

	task automatic drainPipe();
		int waited;
		waited = 0;
		@(negedge clk);
		inValid = 1'b0;
		ce = 1'b1;
		while (expQ.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > 4 * FMA_LAT) begin
				$display("pipeline did not drain, %0d results missing", expQ.size());
				stopWithFailure();
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// scoreboard, compare first then record the newly accepted operation
	// ------------------------------------------------------------------------
	always @(posedge clk) begin : compareOut
		expEntry_t want;
		string name;
		int issued;
		if (!reset && ce) begin
			enCount++;
			if (outValid && expQ.size() == 0) begin
				$display("outValid high with no operation in flight");
				stopWithFailure();
			end else if (outValid) begin
				want = expQ.pop_front();
				name = nameQ.pop_front();
				issued = issueQ.pop_front();
				checkValue({name, " latency"}, FMA_LAT, enCount - issued);
				checkValue({name, " sign"}, want.res.sign, result.sign);
				checkValue({name, " exp"}, want.res.exp, result.exp);
				checkValue({name, " mant"}, want.res.mant, result.mant);
				checkValue({name, " flags"}, want.flg, flags);
			end
			if (inValid) begin
				expQ.push_back(fmaRef(a, b, c, cmd));
				nameQ.push_back(curName);
				issueQ.push_back(enCount);
			end
		end
	end

	// a failed concurrent assertion in the bound checker ends the run too
	always @(posedge clk) begin
		if (i_dut.i_checks.failures != 0) begin
			$display("a concurrent assertion on the DUT outputs failed");
			stopWithFailure();
		end
	end

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin
		void'($urandom(32'hf203b60f));
		reset = 1'b1;
		ce = 1'b1;
		inValid = 1'b0;
		a = '0;
		b = '0;
		c = '0;
		cmd = '0;
		randomCe = 1'b0;
		curName = "none";
		repeat (2) @(negedge clk);
		reset = 1'b0;
		// nothing in flight yet
		repeat (4) begin
			@(negedge clk);
			checkValue("idle after reset", 64'd0, 64'(outValid));
		end
		// ordinary values
		issueOp("1.5*2+0.25", 32'h3fc00000, 32'h40000000, 32'h3e800000, 1'b0, 3'd0);
		issueOp("3*-0.5-1", 32'h40400000, 32'hbf000000, 32'h3f800000, 1'b1, 3'd0);
		// exact cancellation, sign of zero follows rm
		issueOp("2*3-6 rm down", 32'h40000000, 32'h40400000, 32'h40c00000, 1'b1, RM_DOWN);
		issueOp("2*3-6 rm near", 32'h40000000, 32'h40400000, 32'h40c00000, 1'b1, 3'd0);
		issueOp("0*1+0", 32'h00000000, 32'h3f800000, 32'h00000000, 1'b0, 3'd0);
		issueOp("-0*1+-0", 32'h80000000, 32'h3f800000, 32'h80000000, 1'b0, 3'd0);
		// special operands
		issueOp("nan*1+1", 32'h7fc00000, 32'h3f800000, 32'h3f800000, 1'b0, 3'd0);
		issueOp("1*1+nan", 32'h3f800000, 32'h3f800000, 32'hffc00001, 1'b0, 3'd0);
		issueOp("inf*0+1", 32'h7f800000, 32'h00000000, 32'h3f800000, 1'b0, 3'd0);
		issueOp("inf*1-inf", 32'h7f800000, 32'h3f800000, 32'h7f800000, 1'b1, 3'd0);
		issueOp("1*2+-inf", 32'h3f800000, 32'h40000000, 32'hff800000, 1'b0, 3'd0);
		issueOp("-inf*2+1", 32'hff800000, 32'h40000000, 32'h3f800000, 1'b0, 3'd0);
		// wide exponent gaps, clamped shift and sticky
		issueOp("1*1+tiny", 32'h3f800000, 32'h3f800000, 32'h0c000001, 1'b0, 3'd0);
		issueOp("1*1-tiny", 32'h3f800000, 32'h3f800000, 32'h0c000001, 1'b1, 3'd0);
		issueOp("1*1+2^-24", 32'h3f800000, 32'h3f800001, 32'h33800003, 1'b0, 3'd0);
		issueOp("1*1+huge", 32'h3f800000, 32'h3f800000, 32'h70000000, 1'b0, 3'd0);
		issueOp("overflow", 32'h7f000000, 32'h7f000000, 32'h3f800000, 1'b0, 3'd0);
		issueOp("underflow", 32'h00800000, 32'h00800000, 32'h00000000, 1'b0, 3'd0);
		issueOp("denorm*denorm", 32'h00000003, 32'h00400000, 32'h80000000, 1'b0, 3'd0);
		drainPipe();
		// back to back random operations with random stalls
		randomCe = 1'b1;
		for (int i = 0; i < 500; i++) begin
			issueOp($sformatf("random %0d", i), randOperand(), randOperand(), randOperand(),
				1'($urandom_range(1)), 3'($urandom_range(4)));
		end
		randomCe = 1'b0;
		drainPipe();
		if (expQ.size() == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("operations still in flight at the end of the run");
			stopWithFailure();
		end
	end

endmodule

// File: fma_assertions.sv
`timescale 1ns/1ps

module fmaAssertions import fmaPkg::*; (
	input logic clk,
	input logic reset,
	input logic ce,
	input fmaResult_t result,
	input fmaFlags_t flags,
	input logic outValid
);

	// count of failed assertions, watched from the testbench
	int failures = 0;

	// valid chain flushed by reset
	resetFlush: assert property (@(posedge clk) reset |=> !outValid)
		else begin
			$error("outValid high in the cycle after reset");
			failures++;
		end

	// a result is never both nan and inf
	nanInfExclusive: assert property (@(posedge clk) disable iff (reset)
		outValid |-> !(flags.nan && flags.inf))
		else begin
			$error("nan and inf flags both set on a valid result");
			failures++;
		end

	// stalled pipeline holds every output
	stallHoldsValid: assert property (@(posedge clk) disable iff (reset)
		!ce |=> $stable(outValid))
		else begin
			$error("outValid changed while ce was low");
			failures++;
		end

	stallHoldsData: assert property (@(posedge clk) disable iff (reset)
		!ce |=> ($stable(result) && $stable(flags)))
		else begin
			$error("result or flags changed while ce was low");
			failures++;
		end

endmodule

// attached to every fmaTop instance
bind fmaTop fmaAssertions i_checks (
	.clk(clk), .reset(reset), .ce(ce), .result(result), .flags(flags), .outValid(outValid)
);

// File: fmaTop.sv
`timescale 1ns/1ps

module fmaTop import fmaPkg::*; (
	input logic clk,
	input logic reset,
	input logic ce,
	input logic inValid,
	input logic [FP_WID-1:0] a,
	input logic [FP_WID-1:0] b,
	input logic [FP_WID-1:0] c,
	input fmaCmd_t cmd,
	output fmaResult_t result,
	output fmaFlags_t flags,
	output logic outValid
);

	fpOperand_t decA;
	fpOperand_t decB;
	fpOperand_t decC;
	fpOperand_t addendDly;
	fmaProduct_t product;
	fmaAligned_t aligned;
	fmaCmd_t cmdAlign;
	fmaCmd_t cmdAdd;

	// ------------------------------------------------------------------------
	// clock 1, operand decode
	// ------------------------------------------------------------------------
	fmaDecode i_decA (.clk(clk), .ce(ce), .operand(a), .decoded(decA));
	fmaDecode i_decB (.clk(clk), .ce(ce), .operand(b), .decoded(decB));
	fmaDecode i_decC (.clk(clk), .ce(ce), .operand(c), .decoded(decC));

	// ------------------------------------------------------------------------
	// clocks 2-3, multiply, addend waits alongside
	// ------------------------------------------------------------------------
	fmaMultiplier i_mul (.clk(clk), .ce(ce), .opA(decA), .opB(decB), .product(product));

	fmaDelayLine #(.payload_t(fpOperand_t), .DEPTH(MUL_LAT)) i_addendDly (
		.clk(clk), .reset(reset), .ce(ce), .din(decC), .dout(addendDly)
	);

	// command tapped where the aligner and the adder need it
	fmaDelayLine #(.payload_t(fmaCmd_t), .DEPTH(MUL_LAT + 1)) i_cmdAlignDly (
		.clk(clk), .reset(reset), .ce(ce), .din(cmd), .dout(cmdAlign)
	);
	fmaDelayLine #(.payload_t(fmaCmd_t), .DEPTH(ALIGN_LAT)) i_cmdAddDly (
		.clk(clk), .reset(reset), .ce(ce), .din(cmdAlign), .dout(cmdAdd)
	);

	// ------------------------------------------------------------------------
	// clocks 4-5 align, clock 6 add
	// ------------------------------------------------------------------------
	fmaAligner i_align (
		.clk(clk), .ce(ce), .product(product), .addend(addendDly), .cmd(cmdAlign),
		.aligned(aligned)
	);

	fmaAdder i_add (
		.clk(clk), .ce(ce), .aligned(aligned), .cmd(cmdAdd), .result(result),
		.flags(flags)
	);

	// valid bit, the only state cleared by reset
	fmaDelayLine #(.payload_t(logic), .DEPTH(FMA_LAT), .CLEAR(1'b1)) i_validDly (
		.clk(clk), .reset(reset), .ce(ce), .din(inValid), .dout(outValid)
	);

endmodule

// File: fmaAdder.sv
`timescale 1ns/1ps

module fmaAdder import fmaPkg::*; (
	input logic clk,
	input logic ce,
	input fmaAligned_t aligned,
	input fmaCmd_t cmd,
	output fmaResult_t result,
	output fmaFlags_t flags
);

	logic [SUM_W-1:0] sum;
	logic signed [WEXP_W-1:0] resExp;
	logic sumZero;
	logic anyNan;
	logic anyInf;
	logic infMinusInf;
	logic cancel;
	fmaResult_t nextResult;
	fmaFlags_t nextFlags;

	// ------------------------------------------------------------------------
	// magnitude add / subtract, smaller always comes off the larger
	// ------------------------------------------------------------------------
	assign sum = aligned.effSub ?
		SUM_W'(aligned.larger) - SUM_W'(aligned.smaller) :
		SUM_W'(aligned.larger) + SUM_W'(aligned.smaller);

	assign resExp = aligned.exp;
	assign sumZero = (sum == '0);

	// special cases
	assign infMinusInf = aligned.productInf & aligned.addendCls.inf & aligned.effSub;
	assign anyNan = aligned.productNan | aligned.addendCls.nan | infMinusInf;
	assign anyInf = aligned.productInf | aligned.addendCls.inf;
	// exact cancellation of two equal values, also two zeros of opposite sign
	assign cancel = aligned.effSub & aligned.magEq;

	always_comb begin
		nextResult = '0;
		nextFlags = '0;
		if (anyNan) begin
			// nan is a flag only, fields stay zero
			nextFlags.nan = 1'b1;
		end else if (anyInf) begin
			// aligner already made the infinity the larger operand
			nextFlags.inf = 1'b1;
			nextResult.sign = aligned.sign;
		end else begin
			// exact zero is negative only when rounding down,
			// zeros of equal sign keep that sign through aligned.sign
			nextResult.sign = cancel ? (cmd.rm == RM_DOWN) : aligned.sign;
			nextResult.exp = resExp;
			nextResult.mant = sum;
			nextFlags.zero = sumZero;
			// still unnormalized, the normalizer sorts out the carry bit
			nextFlags.over = resExp >= EXP_MAX;
			nextFlags.under = ~sumZero & (resExp <= 0);
		end
	end

	// ------------------------------------------------------------------------
	// output register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (ce) begin
			result <= nextResult;
			flags <= nextFlags;
		end
	end

endmodule

// File: fmaAligner.sv
`timescale 1ns/1ps

module fmaAligner import fmaPkg::*; (
	input logic clk,
	input logic ce,
	input fmaProduct_t product,
	input fpOperand_t addend,
	input fmaCmd_t cmd,
	output fmaAligned_t aligned
);

	logic [ALIGN_W-1:0] prodAligned;
	logic [ALIGN_W-1:0] addAligned;
	logic signed [WEXP_W-1:0] addExp;
	logic signed [WEXP_W-1:0] expDiff;
	logic addSign;
	logic expGt;
	logic expEq;
	logic prodZero;
	logic prodLarger;
	logic [SHIFT_W-1:0] shiftAmt;
	fmaAligned_t stage1;
	logic [SHIFT_W-1:0] shift1;
	logic [ALIGN_W-1:0] shifted;
	logic [ALIGN_W-1:0] lostMask;
	logic sticky;

	// ------------------------------------------------------------------------
	// stage 1
	// compare magnitudes and pick the larger operand
	// ------------------------------------------------------------------------
	// both operands get a guard and a sticky bit at the bottom
	assign prodAligned = {product.mant, 2'b00};
	// addend moved up 23 so its point lines up with the product
	assign addAligned = ALIGN_W'({addend.mant, {FRAC_W+2{1'b0}}});
	assign addExp = WEXP_W'(addend.exp);
	// sign of the addend as it enters the sum
	assign addSign = addend.sign ^ cmd.op;

	assign expGt = product.exp > addExp;
	assign expEq = product.exp == addExp;
	assign prodZero = (product.mant == '0);

	always_comb begin
		// an infinity always counts as larger, so its sign becomes the result sign
		// zero mantissas lose the compare
		if (product.productInf) begin
			prodLarger = 1'b1;
		end else if (addend.cls.inf) begin
			prodLarger = 1'b0;
		end else if (addend.cls.zero) begin
			prodLarger = 1'b1;
		end else if (prodZero) begin
			prodLarger = 1'b0;
		end else begin
			prodLarger = expGt | (expEq & (prodAligned >= addAligned));
		end

		expDiff = prodLarger ? product.exp - addExp : addExp - product.exp;
		// negative only on an override, where the smaller one does not count
		if (expDiff < 0) begin
			shiftAmt = '0;
		end else if (expDiff > ALIGN_W) begin
			shiftAmt = SHIFT_W'(ALIGN_W);
		end else begin
			shiftAmt = SHIFT_W'(expDiff);
		end
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			stage1.larger <= prodLarger ? prodAligned : addAligned;
			stage1.smaller <= prodLarger ? addAligned : prodAligned;
			stage1.exp <= prodLarger ? product.exp : addExp;
			stage1.sign <= prodLarger ? product.sign : addSign;
			stage1.effSub <= product.sign ^ addSign;
			// equal values, two zeros count as equal whatever the exponents
			stage1.magEq <= (expEq & (prodAligned == addAligned)) |
				(prodZero & (addAligned == '0));
			stage1.productNan <= product.productNan;
			stage1.productInf <= product.productInf;
			stage1.addendCls <= addend.cls;
			shift1 <= shiftAmt;
		end
	end

	// ------------------------------------------------------------------------
	// stage 2
	// right shift the smaller operand, fold lost bits into sticky
	// ------------------------------------------------------------------------
	assign shifted = stage1.smaller >> shift1;
	// ones under every bit position that falls off the bottom
	assign lostMask = ~({ALIGN_W{1'b1}} << shift1);
	assign sticky = |(stage1.smaller & lostMask);

	always_ff @(posedge clk) begin
		if (ce) begin
			aligned <= stage1;
			aligned.smaller <= {shifted[ALIGN_W-1:1], shifted[0] | sticky};
		end
	end

endmodule

// File: fmaMultiplier.sv
`timescale 1ns/1ps

module fmaMultiplier import fmaPkg::*; (
	input logic clk,
	input logic ce,
	input fpOperand_t opA,
	input fpOperand_t opB,
	output fmaProduct_t product
);

	// ------------------------------------------------------------------------
	// stage 1
	// four 12x12 partial products, exponent sum, special classes
	// ------------------------------------------------------------------------
	logic [2*PART_W-1:0] p00;
	logic [2*PART_W-1:0] p01;
	logic [2*PART_W-1:0] p10;
	logic [2*PART_W-1:0] p11;
	logic signed [WEXP_W-1:0] expSum;
	logic signed [WEXP_W-1:0] exp1;
	logic sign1;
	logic nan1;
	logic inf1;
	logic zero1;
	logic [PROD_W-1:0] prodSum;

	// unbiased sum, can go negative for tiny products
	assign expSum = WEXP_W'(opA.exp) + WEXP_W'(opB.exp) - WEXP_W'(EXP_BIAS);

	always_ff @(posedge clk) begin
		if (ce) begin
			// low half x low half, up to high x high
			p00 <= opA.mant[PART_W-1:0] * opB.mant[PART_W-1:0];
			p01 <= opA.mant[MANT_W-1:PART_W] * opB.mant[PART_W-1:0];
			p10 <= opA.mant[PART_W-1:0] * opB.mant[MANT_W-1:PART_W];
			p11 <= opA.mant[MANT_W-1:PART_W] * opB.mant[MANT_W-1:PART_W];
			exp1 <= expSum;
			sign1 <= opA.sign ^ opB.sign;
			// nan in, or inf times zero
			nan1 <= opA.cls.nan | opB.cls.nan |
				(opA.cls.inf & opB.cls.zero) | (opB.cls.inf & opA.cls.zero);
			inf1 <= opA.cls.inf | opB.cls.inf;
			zero1 <= opA.cls.zero | opB.cls.zero;
		end
	end

	// ------------------------------------------------------------------------
	// stage 2
	// sum of the shifted partial products
	// ------------------------------------------------------------------------
	// outer products are disjoint so they simply concatenate,
	// cross products sit one half up
	assign prodSum = {p11, p00} +
		PROD_W'({p01, {PART_W{1'b0}}}) +
		PROD_W'({p10, {PART_W{1'b0}}});

	always_ff @(posedge clk) begin
		if (ce) begin
			product.sign <= sign1;
			// zero product gets exponent zero so the addend always wins
			product.exp <= zero1 ? '0 : exp1;
			product.mant <= prodSum;
			product.productNan <= nan1;
			product.productInf <= inf1;
		end
	end

endmodule

// File: fmaDecode.sv
`timescale 1ns/1ps

module fmaDecode import fmaPkg::*; (
	input logic clk,
	input logic ce,
	input logic [FP_WID-1:0] operand,
	output fpOperand_t decoded
);

	logic sign;
	logic [EXP_W-1:0] expField;
	logic [FRAC_W-1:0] frac;
	logic expZero;
	logic expOnes;
	logic fracZero;
	fpOperand_t next;

	// raw field split
	assign sign = operand[FP_WID-1];
	assign expField = operand[FP_WID-2:FRAC_W];
	assign frac = operand[FRAC_W-1:0];

	assign expZero = (expField == '0);
	assign expOnes = (expField == EXP_W'(EXP_MAX));
	assign fracZero = (frac == '0);

	always_comb begin
		next.sign = sign;
		// a zero exponent field acts as exponent 1 without the hidden bit
		next.exp = expZero ? EXP_W'(1) : expField;
		next.mant = {~expZero, frac};
		// operand class
		next.cls.zero = expZero & fracZero;
		next.cls.denorm = expZero & ~fracZero;
		next.cls.inf = expOnes & fracZero;
		next.cls.nan = expOnes & ~fracZero;
	end

	// single register stage
	always_ff @(posedge clk) begin
		if (ce) begin
			decoded <= next;
		end
	end

endmodule

// File: fmaDelayLine.sv
`timescale 1ns/1ps

module fmaDelayLine #(
	parameter type payload_t = logic,
	parameter int DEPTH = 1,
	// clear the chain on reset, only set for control bits
	parameter bit CLEAR = 1'b0
) (
	input logic clk,
	input logic reset,
	input logic ce,
	input payload_t din,
	output payload_t dout
);

	payload_t stages [DEPTH];

	always_ff @(posedge clk) begin
		if (CLEAR && reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				stages[i] <= '0;
			end
		end else if (ce) begin
			stages[0] <= din;
			// shift towards the tap
			for (int i = 1; i < DEPTH; i++) begin
				stages[i] <= stages[i-1];
			end
		end
	end

	assign dout = stages[DEPTH-1];

endmodule

// File: fmaPkg.sv
package fmaPkg;

	// ------------------------------------------------------------------------
	// binary32 format
	// ------------------------------------------------------------------------
	localparam int FP_WID = 32;
	localparam int EXP_W = 8;
	localparam int FRAC_W = 23;
	// fraction plus the hidden bit
	localparam int MANT_W = 24;

	// product of two mantissas, binary point after bit 46
	localparam int PROD_W = 48;
	// product plus guard and sticky, binary point after bit 48
	localparam int ALIGN_W = 50;
	// one carry bit above the aligned operands
	localparam int SUM_W = 51;
	// signed working exponent, wide enough for product over/underflow
	localparam int WEXP_W = 10;

	localparam int EXP_BIAS = 127;
	// all ones exponent field, inf / nan
	localparam int EXP_MAX = 255;

	// round toward minus infinity
	localparam logic [2:0] RM_DOWN = 3'd3;

	// ------------------------------------------------------------------------
	// pipeline depths, counted in enabled clocks
	// ------------------------------------------------------------------------
	localparam int MUL_LAT = 2;
	localparam int ALIGN_LAT = 2;
	// decode + multiplier + aligner + adder
	localparam int FMA_LAT = 6;

	// half mantissa for the partial products
	localparam int PART_W = 12;
	// shift amount covers 0..ALIGN_W
	localparam int SHIFT_W = 6;

	// ------------------------------------------------------------------------
	// shared types
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic zero;
		logic inf;
		logic nan;
		logic denorm;
	} fpClass_t;

	// exp is the effective exponent, 1 for a denormal or zero
	typedef struct packed {
		logic sign;
		logic [EXP_W-1:0] exp;
		logic [MANT_W-1:0] mant;
		fpClass_t cls;
	} fpOperand_t;

	// op: 0 add, 1 subtract
	typedef struct packed {
		logic op;
		logic [2:0] rm;
	} fmaCmd_t;

	typedef struct packed {
		logic sign;
		logic signed [WEXP_W-1:0] exp;
		logic [PROD_W-1:0] mant;
		// input nan or inf times zero
		logic productNan;
		logic productInf;
	} fmaProduct_t;

	typedef struct packed {
		logic [ALIGN_W-1:0] larger;
		logic [ALIGN_W-1:0] smaller;
		logic signed [WEXP_W-1:0] exp;
		// sign of the larger operand, op already folded into the addend
		logic sign;
		logic effSub;
		logic magEq;
		logic productNan;
		logic productInf;
		fpClass_t addendCls;
	} fmaAligned_t;

	typedef struct packed {
		logic zero;
		logic inf;
		logic nan;
		logic over;
		logic under;
	} fmaFlags_t;

	// value = (-1)^sign * mant * 2^(exp - 127 - 48)
	typedef struct packed {
		logic sign;
		logic signed [WEXP_W-1:0] exp;
		logic [SUM_W-1:0] mant;
	} fmaResult_t;

endpackage
